// File: design/rv_cfg.svh
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// Machine word width for RV32I
`define XLEN 32

// Architectural register index width, 32 registers
`define REG_INDEX_SIZE 5

`endif

// File: design/rv_pkg.sv
`include "rv_cfg.svh"

package rv_pkg;

    // One data word
    typedef logic [`XLEN-1:0] xlen_t;

    // Architectural register index
    typedef logic [`REG_INDEX_SIZE-1:0] reg_index_t;

    // Conditional branch kinds, encoded as funct3
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } branch_cond_e;

endpackage

// File: design/reg_file.sv
`timescale 1ns/1ns
`include "rv_cfg.svh"

module reg_file (
    input  logic               clk_i,
    input  logic               reset_i,
    input  rv_pkg::reg_index_t rs1_index_i,
    input  rv_pkg::reg_index_t rs2_index_i,
    output rv_pkg::xlen_t      rs1_data_o,
    output rv_pkg::xlen_t      rs2_data_o,
    input  logic               wr_en_i,
    input  rv_pkg::reg_index_t wr_index_i,
    input  rv_pkg::xlen_t      wr_data_i
);

    localparam int NUM_REGS = 1 << `REG_INDEX_SIZE;

    rv_pkg::xlen_t regs_q [1:NUM_REGS-1]; // x0 has no storage

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en_i && (wr_index_i != '0)) begin
            regs_q[wr_index_i] <= wr_data_i; // Writes to x0 dropped
        end
    end

    // No write-through, a same-cycle write reaches decode via mem2wb forwarding
    assign rs1_data_o = (rs1_index_i == '0) ? '0 : regs_q[rs1_index_i];
    assign rs2_data_o = (rs2_index_i == '0) ? '0 : regs_q[rs2_index_i];

endmodule

// File: design/id_forward.sv
`timescale 1ns/1ns

module id_forward (
    input  logic               inst_jump_i,
    input  logic               inst_branch_i,
    input  logic               id_rs1_en_i,
    input  logic               id_rs2_en_i,
    input  logic               id2ex_rd_en_i,
    input  logic               ex2mem_rd_en_i,
    input  logic               mem2wb_rd_en_i,
    input  rv_pkg::reg_index_t id_rs1_index_i,
    input  rv_pkg::reg_index_t id_rs2_index_i,
    input  rv_pkg::reg_index_t id2ex_rd_index_i,
    input  rv_pkg::reg_index_t ex2mem_rd_index_i,
    input  rv_pkg::reg_index_t mem2wb_rd_index_i,
    output logic               rs1_src_reg_o,
    output logic               rs1_src_id2ex_o,
    output logic               rs1_src_ex2mem_o,
    output logic               rs1_src_mem2wb_o,
    output logic               rs2_src_reg_o,
    output logic               rs2_src_id2ex_o,
    output logic               rs2_src_ex2mem_o,
    output logic               rs2_src_mem2wb_o
);

    // A stage holds a newer value of the source register
    function automatic logic stage_hit(
        input logic               rd_en,
        input rv_pkg::reg_index_t rd_index,
        input rv_pkg::reg_index_t src_index
    );
        return rd_en && (rd_index != '0) && (rd_index == src_index);
    endfunction

    logic rs1_fwd_ok;
    logic rs2_fwd_ok;
    logic rs1_hit_id2ex, rs1_hit_ex2mem, rs1_hit_mem2wb;
    logic rs2_hit_id2ex, rs2_hit_ex2mem, rs2_hit_mem2wb;

    assign rs1_fwd_ok = id_rs1_en_i & (inst_jump_i | inst_branch_i); // JALR uses rs1
    assign rs2_fwd_ok = id_rs2_en_i & inst_branch_i; // Jumps never read rs2

    assign rs1_hit_id2ex  = rs1_fwd_ok & stage_hit(id2ex_rd_en_i, id2ex_rd_index_i, id_rs1_index_i);
    assign rs1_hit_ex2mem = rs1_fwd_ok & stage_hit(ex2mem_rd_en_i, ex2mem_rd_index_i, id_rs1_index_i);
    assign rs1_hit_mem2wb = rs1_fwd_ok & stage_hit(mem2wb_rd_en_i, mem2wb_rd_index_i, id_rs1_index_i);
    assign rs2_hit_id2ex  = rs2_fwd_ok & stage_hit(id2ex_rd_en_i, id2ex_rd_index_i, id_rs2_index_i);
    assign rs2_hit_ex2mem = rs2_fwd_ok & stage_hit(ex2mem_rd_en_i, ex2mem_rd_index_i, id_rs2_index_i);
    assign rs2_hit_mem2wb = rs2_fwd_ok & stage_hit(mem2wb_rd_en_i, mem2wb_rd_index_i, id_rs2_index_i);

    // Youngest stage wins
    assign rs1_src_id2ex_o  = rs1_hit_id2ex;
    assign rs1_src_ex2mem_o = ~rs1_hit_id2ex & rs1_hit_ex2mem;
    assign rs1_src_mem2wb_o = ~rs1_hit_id2ex & ~rs1_hit_ex2mem & rs1_hit_mem2wb;
    assign rs1_src_reg_o    = ~(rs1_hit_id2ex | rs1_hit_ex2mem | rs1_hit_mem2wb);

    assign rs2_src_id2ex_o  = rs2_hit_id2ex;
    assign rs2_src_ex2mem_o = ~rs2_hit_id2ex & rs2_hit_ex2mem;
    assign rs2_src_mem2wb_o = ~rs2_hit_id2ex & ~rs2_hit_ex2mem & rs2_hit_mem2wb;
    assign rs2_src_reg_o    = ~(rs2_hit_id2ex | rs2_hit_ex2mem | rs2_hit_mem2wb);

endmodule

// File: design/branch_resolve.sv
`timescale 1ns/1ns
`include "rv_cfg.svh"

module branch_resolve (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 inst_jump_i,
    input  logic                 inst_branch_i,
    input  logic                 id_rs1_en_i,
    input  rv_pkg::branch_cond_e cond_i,
    input  rv_pkg::xlen_t        pc_i,
    input  rv_pkg::xlen_t        imm_i,
    input  rv_pkg::xlen_t        rf_rs1_i,
    input  rv_pkg::xlen_t        rf_rs2_i,
    input  rv_pkg::xlen_t        id2ex_data_i,
    input  rv_pkg::xlen_t        ex2mem_data_i,
    input  rv_pkg::xlen_t        mem2wb_data_i,
    input  logic                 rs1_src_reg_i,
    input  logic                 rs1_src_id2ex_i,
    input  logic                 rs1_src_ex2mem_i,
    input  logic                 rs1_src_mem2wb_i,
    input  logic                 rs2_src_reg_i,
    input  logic                 rs2_src_id2ex_i,
    input  logic                 rs2_src_ex2mem_i,
    input  logic                 rs2_src_mem2wb_i,
    output logic                 redirect_o,
    output rv_pkg::xlen_t        target_o,
    output rv_pkg::xlen_t        link_o
);

    rv_pkg::xlen_t rs1_val;
    rv_pkg::xlen_t rs2_val;
    rv_pkg::xlen_t jalr_sum;
    rv_pkg::xlen_t target_next;
    logic          is_jalr;
    logic          cond_true;
    logic          taken;

    // Selects are one-hot, so an AND-OR mux is enough
    assign rs1_val = ({`XLEN{rs1_src_reg_i}}    & rf_rs1_i)
                   | ({`XLEN{rs1_src_id2ex_i}}  & id2ex_data_i)
                   | ({`XLEN{rs1_src_ex2mem_i}} & ex2mem_data_i)
                   | ({`XLEN{rs1_src_mem2wb_i}} & mem2wb_data_i);

    assign rs2_val = ({`XLEN{rs2_src_reg_i}}    & rf_rs2_i)
                   | ({`XLEN{rs2_src_id2ex_i}}  & id2ex_data_i)
                   | ({`XLEN{rs2_src_ex2mem_i}} & ex2mem_data_i)
                   | ({`XLEN{rs2_src_mem2wb_i}} & mem2wb_data_i);

    always_comb begin
        case (cond_i)
            rv_pkg::BEQ:  cond_true = (rs1_val == rs2_val);
            rv_pkg::BNE:  cond_true = (rs1_val != rs2_val);
            rv_pkg::BLT:  cond_true = ($signed(rs1_val) < $signed(rs2_val));
            rv_pkg::BGE:  cond_true = ($signed(rs1_val) >= $signed(rs2_val));
            rv_pkg::BLTU: cond_true = (rs1_val < rs2_val);
            rv_pkg::BGEU: cond_true = (rs1_val >= rs2_val);
            default:      cond_true = 1'b0; // funct3 2 and 3 are not branches
        endcase
    end

    assign is_jalr  = inst_jump_i & id_rs1_en_i;
    assign taken    = inst_jump_i | (inst_branch_i & cond_true);
    assign jalr_sum = rs1_val + imm_i;

    assign target_next = is_jalr ? {jalr_sum[`XLEN-1:1], 1'b0} : (pc_i + imm_i);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            redirect_o <= 1'b0;
            target_o   <= '0;
            link_o     <= '0;
        end else begin
            redirect_o <= taken; // One-cycle pulse per taken request
            if (inst_jump_i || inst_branch_i) begin
                target_o <= target_next;
            end
            if (inst_jump_i) begin
                link_o <= pc_i + `XLEN'(4); // Return address
            end
        end
    end

endmodule

// File: design/id_branch_unit.sv
`timescale 1ns/1ns

module id_branch_unit (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 inst_jump_i,
    input  logic                 inst_branch_i,
    input  rv_pkg::branch_cond_e cond_i,
    input  rv_pkg::xlen_t        pc_i,
    input  rv_pkg::xlen_t        imm_i,
    input  logic                 id_rs1_en_i,
    input  logic                 id_rs2_en_i,
    input  rv_pkg::reg_index_t   id_rs1_index_i,
    input  rv_pkg::reg_index_t   id_rs2_index_i,
    input  logic                 id2ex_rd_en_i,
    input  rv_pkg::reg_index_t   id2ex_rd_index_i,
    input  rv_pkg::xlen_t        id2ex_data_i,
    input  logic                 ex2mem_rd_en_i,
    input  rv_pkg::reg_index_t   ex2mem_rd_index_i,
    input  rv_pkg::xlen_t        ex2mem_data_i,
    input  logic                 mem2wb_rd_en_i,
    input  rv_pkg::reg_index_t   mem2wb_rd_index_i,
    input  rv_pkg::xlen_t        mem2wb_data_i,
    output logic                 redirect_o,
    output rv_pkg::xlen_t        target_o,
    output rv_pkg::xlen_t        link_o
);

    rv_pkg::xlen_t rf_rs1_data;
    rv_pkg::xlen_t rf_rs2_data;
    logic          rs1_src_reg, rs1_src_id2ex, rs1_src_ex2mem, rs1_src_mem2wb;
    logic          rs2_src_reg, rs2_src_id2ex, rs2_src_ex2mem, rs2_src_mem2wb;

    reg_file reg_file_i (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .rs1_index_i (id_rs1_index_i),
        .rs2_index_i (id_rs2_index_i),
        .rs1_data_o  (rf_rs1_data),
        .rs2_data_o  (rf_rs2_data),
        .wr_en_i     (mem2wb_rd_en_i), // Writeback shares the mem2wb triple
        .wr_index_i  (mem2wb_rd_index_i),
        .wr_data_i   (mem2wb_data_i)
    );

    id_forward id_forward_i (
        .inst_jump_i       (inst_jump_i),
        .inst_branch_i     (inst_branch_i),
        .id_rs1_en_i       (id_rs1_en_i),
        .id_rs2_en_i       (id_rs2_en_i),
        .id2ex_rd_en_i     (id2ex_rd_en_i),
        .ex2mem_rd_en_i    (ex2mem_rd_en_i),
        .mem2wb_rd_en_i    (mem2wb_rd_en_i),
        .id_rs1_index_i    (id_rs1_index_i),
        .id_rs2_index_i    (id_rs2_index_i),
        .id2ex_rd_index_i  (id2ex_rd_index_i),
        .ex2mem_rd_index_i (ex2mem_rd_index_i),
        .mem2wb_rd_index_i (mem2wb_rd_index_i),
        .rs1_src_reg_o     (rs1_src_reg),
        .rs1_src_id2ex_o   (rs1_src_id2ex),
        .rs1_src_ex2mem_o  (rs1_src_ex2mem),
        .rs1_src_mem2wb_o  (rs1_src_mem2wb),
        .rs2_src_reg_o     (rs2_src_reg),
        .rs2_src_id2ex_o   (rs2_src_id2ex),
        .rs2_src_ex2mem_o  (rs2_src_ex2mem),
        .rs2_src_mem2wb_o  (rs2_src_mem2wb)
    );

    branch_resolve branch_resolve_i (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .inst_jump_i      (inst_jump_i),
        .inst_branch_i    (inst_branch_i),
        .id_rs1_en_i      (id_rs1_en_i),
        .cond_i           (cond_i),
        .pc_i             (pc_i),
        .imm_i            (imm_i),
        .rf_rs1_i         (rf_rs1_data),
        .rf_rs2_i         (rf_rs2_data),
        .id2ex_data_i     (id2ex_data_i),
        .ex2mem_data_i    (ex2mem_data_i),
        .mem2wb_data_i    (mem2wb_data_i),
        .rs1_src_reg_i    (rs1_src_reg),
        .rs1_src_id2ex_i  (rs1_src_id2ex),
        .rs1_src_ex2mem_i (rs1_src_ex2mem),
        .rs1_src_mem2wb_i (rs1_src_mem2wb),
        .rs2_src_reg_i    (rs2_src_reg),
        .rs2_src_id2ex_i  (rs2_src_id2ex),
        .rs2_src_ex2mem_i (rs2_src_ex2mem),
        .rs2_src_mem2wb_i (rs2_src_mem2wb),
        .redirect_o       (redirect_o),
        .target_o         (target_o),
        .link_o           (link_o)
    );

endmodule

// File: tb/id_branch_props.sv
`timescale 1ns/1ns

module id_branch_props (
    input logic          clk_i,
    input logic          reset_i,
    input logic          rs1_src_reg_i,
    input logic          rs1_src_id2ex_i,
    input logic          rs1_src_ex2mem_i,
    input logic          rs1_src_mem2wb_i,
    input logic          rs2_src_reg_i,
    input logic          rs2_src_id2ex_i,
    input logic          rs2_src_ex2mem_i,
    input logic          rs2_src_mem2wb_i,
    input logic          redirect_i,
    input rv_pkg::xlen_t target_i
);

    int fail_count = 0; // Read by the testbench at the end of the run

    rs1_select_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
        $onehot({rs1_src_reg_i, rs1_src_id2ex_i, rs1_src_ex2mem_i, rs1_src_mem2wb_i}))
    else begin
        fail_count++;
        $error("rs1 operand select is not one-hot");
    end

    rs2_select_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
        $onehot({rs2_src_reg_i, rs2_src_id2ex_i, rs2_src_ex2mem_i, rs2_src_mem2wb_i}))
    else begin
        fail_count++;
        $error("rs2 operand select is not one-hot");
    end

    // Quiet while in reset and in the first cycle out of it
    redirect_quiet_in_reset: assert property (@(posedge clk_i) reset_i |=> !redirect_i)
    else begin
        fail_count++;
        $error("redirect high during reset");
    end

    redirect_quiet_after_reset: assert property (@(posedge clk_i) $fell(reset_i) |=> !redirect_i)
    else begin
        fail_count++;
        $error("redirect high in the cycle after reset");
    end

    target_aligned: assert property (@(posedge clk_i) disable iff (reset_i)
        redirect_i |-> !target_i[0])
    else begin
        fail_count++;
        $error("redirect target has bit 0 set");
    end

endmodule

// File: tb/tb_id_branch_unit.sv
`timescale 1ns/1ns
`include "rv_cfg.svh"

module tb_id_branch_unit;

    localparam int CLK_PERIOD       = 10;
    localparam int RESET_CYCLES     = 8;
    localparam int REDIRECT_TIMEOUT = 4;
    localparam int SIM_LIMIT_NS     = 100000;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
    localparam rv_pkg::branch_cond_e CONDS [6] = '{rv_pkg::BEQ, rv_pkg::BNE, rv_pkg::BLT,
                                                   rv_pkg::BGE, rv_pkg::BLTU, rv_pkg::BGEU};

    logic                 clk_i;
    logic                 reset_i;
    logic                 inst_jump_i;
    logic                 inst_branch_i;
    rv_pkg::branch_cond_e cond_i;
    rv_pkg::xlen_t        pc_i;
    rv_pkg::xlen_t        imm_i;
    logic                 id_rs1_en_i;
    logic                 id_rs2_en_i;
    rv_pkg::reg_index_t   id_rs1_index_i;
    rv_pkg::reg_index_t   id_rs2_index_i;
    logic                 id2ex_rd_en_i;
    rv_pkg::reg_index_t   id2ex_rd_index_i;
    rv_pkg::xlen_t        id2ex_data_i;
    logic                 ex2mem_rd_en_i;
    rv_pkg::reg_index_t   ex2mem_rd_index_i;
    rv_pkg::xlen_t        ex2mem_data_i;
    logic                 mem2wb_rd_en_i;
    rv_pkg::reg_index_t   mem2wb_rd_index_i;
    rv_pkg::xlen_t        mem2wb_data_i;
    logic                 redirect_o;
    rv_pkg::xlen_t        target_o;
    rv_pkg::xlen_t        link_o;

    int          errors = 0;
    int          checks = 0;
    logic [31:0] lfsr_state;

    id_branch_unit id_branch_unit_i (.*);

    bind id_branch_unit id_branch_props props_i (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .rs1_src_reg_i    (rs1_src_reg),
        .rs1_src_id2ex_i  (rs1_src_id2ex),
        .rs1_src_ex2mem_i (rs1_src_ex2mem),
        .rs1_src_mem2wb_i (rs1_src_mem2wb),
        .rs2_src_reg_i    (rs2_src_reg),
        .rs2_src_id2ex_i  (rs2_src_id2ex),
        .rs2_src_ex2mem_i (rs2_src_ex2mem),
        .rs2_src_mem2wb_i (rs2_src_mem2wb),
        .redirect_i       (redirect_o),
        .target_i         (target_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    task automatic check(input string name, input rv_pkg::xlen_t expected,
                         input rv_pkg::xlen_t actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("ERR %s expected %h actual %h", name, expected, actual);
        end
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
    endfunction

    task automatic rand_word(output rv_pkg::xlen_t word);
        word = '0;
        for (int i = 0; i < `XLEN; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            word = {word[`XLEN-2:0], lfsr_state[0]}; // One step per bit
        end
    endtask

    // RV32I branch rule selected by funct3
    function automatic logic cond_model(input rv_pkg::branch_cond_e cond,
                                        input rv_pkg::xlen_t a, input rv_pkg::xlen_t b);
        rv_pkg::xlen_t sign_flip;
        logic          equal;
        logic          less_u;
        logic          less_s;
        sign_flip = {1'b1, {(`XLEN-1){1'b0}}};
        equal     = (a == b);
        less_u    = (a < b);
        less_s    = ((a ^ sign_flip) < (b ^ sign_flip)); // Biased order equals signed order
        case (cond)
            rv_pkg::BEQ:  return equal;
            rv_pkg::BNE:  return !equal;
            rv_pkg::BLT:  return less_s;
            rv_pkg::BGE:  return !less_s;
            rv_pkg::BLTU: return less_u;
            rv_pkg::BGEU: return !less_u;
            default:      return 1'b0;
        endcase
    endfunction

    task automatic drive_stages(input logic e1, input rv_pkg::reg_index_t i1, input rv_pkg::xlen_t d1,
                                input logic e2, input rv_pkg::reg_index_t i2, input rv_pkg::xlen_t d2,
                                input logic e3, input rv_pkg::reg_index_t i3, input rv_pkg::xlen_t d3);
        id2ex_rd_en_i     <= e1;
        id2ex_rd_index_i  <= i1;
        id2ex_data_i      <= d1;
        ex2mem_rd_en_i    <= e2;
        ex2mem_rd_index_i <= i2;
        ex2mem_data_i     <= d2;
        mem2wb_rd_en_i    <= e3;
        mem2wb_rd_index_i <= i3;
        mem2wb_data_i     <= d3;
    endtask

    task automatic set_stages(input logic e1, input rv_pkg::reg_index_t i1, input rv_pkg::xlen_t d1,
                              input logic e2, input rv_pkg::reg_index_t i2, input rv_pkg::xlen_t d2,
                              input logic e3, input rv_pkg::reg_index_t i3, input rv_pkg::xlen_t d3);
        @(posedge clk_i);
        drive_stages(e1, i1, d1, e2, i2, d2, e3, i3, d3);
    endtask

    task automatic write_reg(input rv_pkg::reg_index_t index, input rv_pkg::xlen_t data);
        set_stages(1'b0, 5'd0, '0, 1'b0, 5'd0, '0, 1'b1, index, data);
    endtask

    task automatic idle_stages();
        set_stages(1'b0, 5'd0, '0, 1'b0, 5'd0, '0, 1'b0, 5'd0, '0);
    endtask

    task automatic issue_request(input logic jump, input logic branch,
                                 input rv_pkg::branch_cond_e cond,
                                 input logic rs1_en, input rv_pkg::reg_index_t rs1,
                                 input logic rs2_en, input rv_pkg::reg_index_t rs2,
                                 input rv_pkg::xlen_t pc, input rv_pkg::xlen_t imm);
        @(posedge clk_i);
        inst_jump_i    <= jump;
        inst_branch_i  <= branch;
        cond_i         <= cond;
        id_rs1_en_i    <= rs1_en;
        id_rs1_index_i <= rs1;
        id_rs2_en_i    <= rs2_en;
        id_rs2_index_i <= rs2;
        pc_i           <= pc;
        imm_i          <= imm;
    endtask

    // Drop the request and move to the middle of cycle N+1
    task automatic end_request();
        @(posedge clk_i);
        inst_jump_i   <= 1'b0;
        inst_branch_i <= 1'b0;
        @(negedge clk_i);
    endtask

    task automatic branch_case(input string name, input rv_pkg::branch_cond_e cond,
                               input rv_pkg::reg_index_t rs1, input rv_pkg::reg_index_t rs2,
                               input rv_pkg::xlen_t pc, input rv_pkg::xlen_t imm,
                               input logic taken);
        issue_request(1'b0, 1'b1, cond, 1'b1, rs1, 1'b1, rs2, pc, imm);
        end_request();
        check(name, `XLEN'(taken), `XLEN'(redirect_o));
        if (taken) begin
            check({name, "_target"}, pc + imm, target_o);
        end
    endtask

    task automatic beq_bne(input string name, input rv_pkg::reg_index_t rs1,
                           input rv_pkg::reg_index_t rs2, input logic equal);
        branch_case({name, "_beq"}, rv_pkg::BEQ, rs1, rs2, 32'h0000_1000, 32'h0000_0080, equal);
        branch_case({name, "_bne"}, rv_pkg::BNE, rs1, rs2, 32'h0000_1000, 32'h0000_0080, !equal);
    endtask

    // Stages go live with the request so x10 in the register file still holds the fourth value
    task automatic forward_case(input string name, input rv_pkg::branch_cond_e cond,
                                input logic e1, input logic e2, input logic e3,
                                input rv_pkg::xlen_t rs2_value, input logic taken);
        write_reg(5'd10, 32'h4444_0004);
        write_reg(5'd11, rs2_value);
        idle_stages();
        issue_request(1'b0, 1'b1, cond, 1'b1, 5'd10, 1'b1, 5'd11,
                      32'h0000_1000, 32'h0000_0080);
        drive_stages(e1, 5'd10, 32'h1111_0001, e2, 5'd10, 32'h2222_0002,
                     e3, 5'd10, 32'h3333_0003);
        end_request();
        check(name, `XLEN'(taken), `XLEN'(redirect_o));
    endtask

    task automatic reg_file_path();
        write_reg(5'd5, 32'h1234_5678);
        write_reg(5'd6, 32'h1234_5678);
        write_reg(5'd7, 32'h0BAD_F00D);
        idle_stages();
        beq_bne("rf_equal", 5'd5, 5'd6, 1'b1);
        beq_bne("rf_differ", 5'd5, 5'd7, 1'b0);
    endtask

    task automatic forward_priority();
        forward_case("fwd_id2ex_beq", rv_pkg::BEQ, 1'b1, 1'b1, 1'b1, 32'h1111_0001, 1'b1);
        forward_case("fwd_id2ex_bne", rv_pkg::BNE, 1'b1, 1'b1, 1'b1, 32'h1111_0001, 1'b0);
        forward_case("fwd_ex2mem_beq", rv_pkg::BEQ, 1'b0, 1'b1, 1'b1, 32'h2222_0002, 1'b1);
        forward_case("fwd_ex2mem_bne", rv_pkg::BNE, 1'b0, 1'b1, 1'b1, 32'h2222_0002, 1'b0);
        forward_case("fwd_mem2wb_beq", rv_pkg::BEQ, 1'b0, 1'b0, 1'b1, 32'h3333_0003, 1'b1);
        forward_case("fwd_mem2wb_bne", rv_pkg::BNE, 1'b0, 1'b0, 1'b1, 32'h3333_0003, 1'b0);
        forward_case("fwd_reg_file_beq", rv_pkg::BEQ, 1'b0, 1'b0, 1'b0, 32'h4444_0004, 1'b1);
        forward_case("fwd_reg_file_bne", rv_pkg::BNE, 1'b0, 1'b0, 1'b0, 32'h4444_0004, 1'b0);
    endtask

    task automatic x0_and_enables();
        write_reg(5'd12, 32'h0000_7777);
        write_reg(5'd13, 32'h0000_7777);
        set_stages(1'b1, 5'd0, 32'h0000_0055, 1'b0, 5'd12, 32'h0000_0066,
                   1'b0, 5'd12, 32'h0000_0077);
        beq_bne("rd_en_low", 5'd12, 5'd13, 1'b1);
        beq_bne("x0_rs1_zero", 5'd0, 5'd14, 1'b1); // x14 untouched since reset
        beq_bne("x0_rs2_zero", 5'd14, 5'd0, 1'b1);
    endtask

    task automatic qualifier_rule();
        set_stages(1'b1, 5'd15, 32'h0000_1001, 1'b1, 5'd16, 32'h0000_9999, 1'b0, 5'd0, '0);
        issue_request(1'b1, 1'b0, rv_pkg::BEQ, 1'b1, 5'd15, 1'b1, 5'd16,
                      32'h0000_2000, 32'h0000_0020);
        end_request();
        check("jalr_redirect", 32'd1, `XLEN'(redirect_o));
        check("jalr_target", (32'h0000_1001 + 32'h0000_0020) & ~32'h1, target_o);
        check("jalr_link", 32'h0000_2004, link_o);
        issue_request(1'b1, 1'b0, rv_pkg::BEQ, 1'b0, 5'd15, 1'b1, 5'd16,
                      32'h0000_2100, 32'h0000_0040);
        end_request();
        check("jal_ignores_rs1", 32'h0000_2140, target_o);
        beq_bne("rs2_fwd_branch", 5'd17, 5'd16, 1'b0);
    endtask

    task automatic condition_sweep();
        rv_pkg::xlen_t a;
        rv_pkg::xlen_t b;
        rv_pkg::xlen_t pc;
        rv_pkg::xlen_t imm;
        for (int c = 0; c < 6; c++) begin
            for (int n = 0; n < 4; n++) begin
                rand_word(a);
                rand_word(b);
                rand_word(pc);
                rand_word(imm);
                if (n == 0) b = a;
                if (n == 1) b = {~a[`XLEN-1], a[`XLEN-2:0]}; // Sign bit differs
                pc[1:0] = 2'b00;
                imm[0]  = 1'b0;
                set_stages(1'b1, 5'd20, a, 1'b1, 5'd21, b, 1'b0, 5'd0, '0);
                branch_case($sformatf("cond_%s_%0d", CONDS[c].name(), n), CONDS[c],
                            5'd20, 5'd21, pc, imm, cond_model(CONDS[c], a, b));
            end
        end
    endtask

    task automatic jal_link_timing();
        int waited;
        idle_stages();
        issue_request(1'b1, 1'b0, rv_pkg::BEQ, 1'b0, 5'd0, 1'b0, 5'd0,
                      32'h0000_3000, 32'h0000_0100);
        end_request();
        waited = 1;
        while (!redirect_o && waited < REDIRECT_TIMEOUT) begin
            @(negedge clk_i);
            waited++;
        end
        if (!redirect_o) begin
            $display("Timed out waiting for the JAL redirect");
            errors++;
        end else begin
            check("jal_latency", 32'd1, `XLEN'(waited));
            check("jal_target", 32'h0000_3100, target_o);
            check("jal_link", 32'h0000_3004, link_o);
            @(negedge clk_i);
            check("jal_pulse_width", 32'd0, `XLEN'(redirect_o));
        end
        issue_request(1'b1, 1'b0, rv_pkg::BEQ, 1'b0, 5'd0, 1'b0, 5'd0,
                      32'h0000_4000, 32'h0000_0010);
        issue_request(1'b1, 1'b0, rv_pkg::BEQ, 1'b0, 5'd0, 1'b0, 5'd0,
                      32'h0000_5000, 32'h0000_0020);
        @(negedge clk_i);
        check("b2b_first_redirect", 32'd1, `XLEN'(redirect_o));
        check("b2b_first_target", 32'h0000_4010, target_o);
        check("b2b_first_link", 32'h0000_4004, link_o);
        end_request();
        check("b2b_second_redirect", 32'd1, `XLEN'(redirect_o));
        check("b2b_second_target", 32'h0000_5020, target_o);
        check("b2b_second_link", 32'h0000_5004, link_o);
        @(negedge clk_i);
        check("b2b_pulse_end", 32'd0, `XLEN'(redirect_o));
    endtask

    initial begin
        #(SIM_LIMIT_NS);
        $display("Simulation ran past its time limit");
        $display("Errors found");
        $finish;
    end

    initial begin
        lfsr_state = 32'd57;
        reset_i    <= 1'b1;
        inst_jump_i <= 1'b0;
        inst_branch_i <= 1'b0;
        cond_i <= rv_pkg::BEQ;
        pc_i <= '0;
        imm_i <= '0;
        id_rs1_en_i <= 1'b0;
        id_rs2_en_i <= 1'b0;
        id_rs1_index_i <= '0;
        id_rs2_index_i <= '0;
        id2ex_rd_en_i <= 1'b0;
        id2ex_rd_index_i <= '0;
        id2ex_data_i <= '0;
        ex2mem_rd_en_i <= 1'b0;
        ex2mem_rd_index_i <= '0;
        ex2mem_data_i <= '0;
        mem2wb_rd_en_i <= 1'b0;
        mem2wb_rd_index_i <= '0;
        mem2wb_data_i <= '0;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk_i);
        end
        reset_i <= 1'b0;
        reg_file_path();
        forward_priority();
        x0_and_enables();
        qualifier_rule();
        condition_sweep();
        jal_link_timing();
        errors = errors + id_branch_unit_i.props_i.fail_count;
        $display("Checks %0d, errors %0d (assertion failures %0d)", checks, errors,
                 id_branch_unit_i.props_i.fail_count);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+design
design/rv_pkg.sv
design/reg_file.sv
design/id_forward.sv
design/branch_resolve.sv
design/id_branch_unit.sv
tb/id_branch_props.sv
tb/tb_id_branch_unit.sv

// File: Makefile
# Verilator build and run for the decode-stage branch unit

VERILATOR ?= verilator
TOP       ?= tb_id_branch_unit
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= No errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS SIM_ARGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
